// ==== sources.f ====
src/afe_pkg.sv
src/hold_timer.sv
src/lock_reset_fsm.sv
src/adc_capture.sv
src/dac_mixer.sv
src/afe_core.sv
verification/afe_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the AFE core testbench

SRCS := $(shell cat sources.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/afe_core_tb: sources.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module afe_core_tb \
		-f sources.f -Mdir obj_dir -o afe_core_tb

# Pass or fail is taken from the log, not from the exit code
run: obj_dir/afe_core_tb verification/afe_vectors_input.txt
	./obj_dir/afe_core_tb > sim.log 2>&1 || true
	@cat sim.log
	@grep -qx "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/afe_vectors_input.txt ====
# name mode asg_a asg_b pid_a pid_b raw_a raw_b raw_dv adc_a adc_b adc_dv dac_a dac_b
# all hex, samples and codes 14 bit, raw words 16 bit, expected outputs after one edge
off_zero       0 0000 0000 0000 0000 0000 0000 0  0000 0000 0 1FFF 1FFF
off_cap_pos    0 0000 0000 0000 0000 1234 FFFC 1  048D 3FFF 1 1FFF 1FFF
off_cap_ends   0 0000 0000 0000 0000 8000 7FFF 1  2000 1FFF 1 1FFF 1FFF
off_cap_nodv   0 0000 0000 0000 0000 ABCD 0003 0  2AF3 0000 0 1FFF 1FFF
off_cap_edge   0 0000 0000 0000 0000 7FFC 8003 1  1FFF 2000 1 1FFF 1FFF
off_sum_small  0 0064 3FFF 0032 3FFE 0000 0000 0  0000 0000 0 1F69 2002
off_sum_limits 0 1000 2000 0FFF 0000 0000 0000 0  0000 0000 0 0000 3FFF
off_sum_neg1   0 3FFF 0000 0000 3FFF 0000 0000 0  0000 0000 0 2000 2000
off_pos_ovf    0 1FFF 1FFF 0001 1FFF 0000 0000 0  0000 0000 0 0000 0000
off_neg_ovf    0 2000 2000 3FFF 2000 0000 0000 0  0000 0000 0 3FFF 3FFF
off_mixed      0 0FA0 1800 3C18 0900 4004 C000 1  1001 3000 1 1447 0000
off_neg_in     0 3000 2710 3000 0001 0000 0000 0  0000 0000 0 3FFF 38EE
off_ovf_edge   0 1000 3000 1000 2FFF 0000 0000 0  0000 0000 0 0000 3FFF
adc_loop_small 1 0064 3FFF 0032 3FFE 1234 5678 0  0096 3FFD 1 1F69 2002
adc_loop_sat   1 1FFF 2000 1FFF 3FFF FFFF FFFF 0  1FFF 2000 1 0000 3FFF
adc_loop_zero  1 0000 0000 0000 0000 8000 0004 1  0000 0000 1 1FFF 1FFF
adc_loop_mixed 1 0FA0 1800 3C18 0900 0000 0000 0  0BB8 1FFF 1 1447 0000
dac_loop_pos   2 0064 0000 0032 0000 1234 FFFC 1  048D 3FFF 1 048D 3FFF
dac_loop_ends  2 1FFF 0000 1FFF 0000 8000 0004 0  2000 0001 0 2000 0001
dac_loop_split 2 0000 0000 0000 0000 4004 C000 1  1001 3000 1 1001 3000
dac_loop_zero  2 0064 0000 0032 0000 0000 0000 0  0000 0000 0 0000 0000
both_small     3 0064 1FFF 0032 0001 ABCD 4004 0  0096 1FFF 1 2AF3 1001
both_neg       3 2000 0000 2000 0000 0000 FFFF 1  2000 0000 1 0000 3FFF
both_mixed     3 3000 2710 3000 0001 7FFF 0003 0  2000 2711 1 1FFF 0000
off_return     0 0000 0000 0000 0000 0008 0010 1  0002 0004 1 1FFF 1FFF
off_idle       0 0001 3FFF 0000 0000 0000 0000 0  0000 0000 0 1FFE 2000

// ==== verification/afe_core_tb.sv ====
// Self-checking afe_core testbench that checks reset release and lock loss and then replays the vector file

`timescale 1ns/100ps

module afe_core_tb;

  import afe_pkg::*;

  localparam int    CLK_HALF      = 4;                     // 8 ns period
  localparam int    RESET_CYCLES  = 3;
  localparam int    RELEASE_EDGES = RST_HOLD_CYCLES + 1;   // Lock edge to core_rst fall
  localparam int    MAX_CYCLES    = 400;                   // Reset plus two holds plus vectors
  localparam string VECTOR_FILE   = "verification/afe_vectors_input.txt";

  logic       adc_clk = 1'b0;
  logic       rst_i;
  logic       pll_locked_i;
  logic       adc_raw_dv_i;
  loop_mode_e loop_mode_i;
  adc_raw_t   adc_raw_a_i;
  adc_raw_t   adc_raw_b_i;
  sample_t    asg_a_i;
  sample_t    asg_b_i;
  sample_t    pid_a_i;
  sample_t    pid_b_i;
  sample_t    adc_a_o;
  sample_t    adc_b_o;
  logic       adc_dv_o;
  dac_code_t  dac_a_o;
  dac_code_t  dac_b_o;
  logic       core_rst_o;

  int err_count;        // Failed checks over the run
  int test_pass;
  int test_fail;
  int cycle_cnt = 0;    // Watchdog

  always #(CLK_HALF) adc_clk = ~adc_clk;

  afe_core uut (
    .adc_clk      (adc_clk     ),
    .rst_i        (rst_i       ),
    .pll_locked_i (pll_locked_i),
    .adc_raw_dv_i (adc_raw_dv_i),
    .loop_mode_i  (loop_mode_i ),
    .adc_raw_a_i  (adc_raw_a_i ),
    .adc_raw_b_i  (adc_raw_b_i ),
    .asg_a_i      (asg_a_i     ),
    .asg_b_i      (asg_b_i     ),
    .pid_a_i      (pid_a_i     ),
    .pid_b_i      (pid_b_i     ),
    .adc_a_o      (adc_a_o     ),
    .adc_b_o      (adc_b_o     ),
    .adc_dv_o     (adc_dv_o    ),
    .dac_a_o      (dac_a_o     ),
    .dac_b_o      (dac_b_o     ),
    .core_rst_o   (core_rst_o  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Reporting helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string test, input string sig,
                                 input logic [15:0] exp, input logic [15:0] act);
    $display("CHECK FAILED %s %s expected %h actual %h", test, sig, exp, act);
    err_count++;
  endtask

  // One line per finished test
  task automatic close_test(input string test, input int errs_before);
    if (err_count == errs_before) begin
      test_pass++;
      $display("[ok]     %s", test);
    end else begin
      test_fail++;
      $display("[failed] %s, %0d bad checks", test, err_count - errs_before);
    end
  endtask

  // Data outputs as they must look under core reset
  task automatic check_reset_outputs(input string test);
    if (adc_dv_o !== 1'b0)
      report_mismatch(test, "adc_dv", 16'h0000, {15'd0, adc_dv_o});
    if (adc_a_o !== 14'h0000)
      report_mismatch(test, "adc_a", 16'h0000, {2'b00, adc_a_o});
    if (adc_b_o !== 14'h0000)
      report_mismatch(test, "adc_b", 16'h0000, {2'b00, adc_b_o});
    if (dac_a_o !== DAC_ZERO_CODE)
      report_mismatch(test, "dac_a", {2'b00, DAC_ZERO_CODE}, {2'b00, dac_a_o});
    if (dac_b_o !== DAC_ZERO_CODE)
      report_mismatch(test, "dac_b", {2'b00, DAC_ZERO_CODE}, {2'b00, dac_b_o});
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reset tests
  ////////////////////////////////////////////////////////////////////////////

  // Entered on the falling edge right after the edge that sampled lock
  task automatic wait_release(input string test);
    int edges;
    edges = 0;
    if (core_rst_o !== 1'b1)
      report_mismatch(test, "core_rst", 16'h0001, {15'd0, core_rst_o});
    check_reset_outputs(test);
    while (core_rst_o === 1'b1 && edges < RELEASE_EDGES + 8) begin
      @(posedge adc_clk);
      @(negedge adc_clk);
      edges++;
      check_reset_outputs(test);               // Data regs still cleared on the falling edge
    end
    if (core_rst_o === 1'b1) begin
      $display("Core reset in %s never released after lock", test);
      err_count++;
    end else if (edges != RELEASE_EDGES) begin
      report_mismatch(test, "release_edges", 16'(RELEASE_EDGES), 16'(edges));
    end
  endtask

  task automatic run_reset_release();
    int errs_before;
    errs_before  = err_count;
    adc_raw_dv_i = 1'b1;                       // Busy inputs that must not leak out
    adc_raw_a_i  = 16'h4004;
    adc_raw_b_i  = 16'hC000;
    asg_a_i      = 14'h0100;
    pid_a_i      = 14'h0010;
    asg_b_i      = 14'h0200;
    pid_b_i      = 14'h0020;
    repeat (4) begin                           // Core held while unlocked
      @(posedge adc_clk);
      @(negedge adc_clk);
      if (core_rst_o !== 1'b1)
        report_mismatch("reset_release", "core_rst", 16'h0001, {15'd0, core_rst_o});
      check_reset_outputs("reset_release");
    end
    pll_locked_i = 1'b1;
    @(posedge adc_clk);                        // Lock sampled here
    @(negedge adc_clk);
    wait_release("reset_release");
    close_test("reset_release", errs_before);
  endtask

  task automatic run_lock_loss();
    int errs_before;
    errs_before = err_count;
    @(posedge adc_clk);                        // First sample in RUN
    @(negedge adc_clk);
    if (adc_dv_o !== 1'b1)
      report_mismatch("lock_loss", "adc_dv", 16'h0001, {15'd0, adc_dv_o});
    if (adc_a_o !== 14'h1001)
      report_mismatch("lock_loss", "adc_a", 16'h1001, {2'b00, adc_a_o});
    pll_locked_i = 1'b0;                       // One cycle glitch
    @(posedge adc_clk);
    @(negedge adc_clk);
    if (core_rst_o !== 1'b1)
      report_mismatch("lock_loss", "core_rst", 16'h0001, {15'd0, core_rst_o});
    pll_locked_i = 1'b1;
    @(posedge adc_clk);                        // Relock sampled and data regs cleared
    @(negedge adc_clk);
    wait_release("lock_loss");                 // Full hold again
    close_test("lock_loss", errs_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Vector replay
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_vectors();
    int               fd;
    int               code;
    int               vec_count;
    int               errs_before;
    logic             done;
    logic [8*32-1:0]  tag;
    logic [8*128-1:0] skip_line;
    string            name;
    logic [1:0]       mode;
    logic [13:0]      asg_a, asg_b, pid_a, pid_b;
    logic [15:0]      raw_a, raw_b;
    logic             raw_dv, exp_dv;
    logic [13:0]      exp_adc_a, exp_adc_b, exp_dac_a, exp_dac_b;
    vec_count = 0;
    done      = 1'b0;
    fd        = $fopen(VECTOR_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the vector file %s", VECTOR_FILE);
      err_count++;
      done = 1'b1;
    end
    while (!done) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        done = 1'b1;                           // End of file
      end else if (tag == "#") begin
        code = $fgets(skip_line, fd);          // Column notes
      end else begin
        name = $sformatf("%0s", tag);
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                       mode, asg_a, asg_b, pid_a, pid_b, raw_a, raw_b, raw_dv,
                       exp_adc_a, exp_adc_b, exp_dv, exp_dac_a, exp_dac_b);
        if (code != 13) begin
          $display("Vector %s has missing or unreadable fields", name);
          err_count++;
          done = 1'b1;
        end else begin
          errs_before  = err_count;
          vec_count++;
          loop_mode_i  = loop_mode_e'(mode);   // Driven on the falling edge
          asg_a_i      = asg_a;
          asg_b_i      = asg_b;
          pid_a_i      = pid_a;
          pid_b_i      = pid_b;
          adc_raw_a_i  = raw_a;
          adc_raw_b_i  = raw_b;
          adc_raw_dv_i = raw_dv;
          @(posedge adc_clk);
          @(negedge adc_clk);                  // Registered result now stable
          if (adc_a_o !== exp_adc_a)
            report_mismatch(name, "adc_a", {2'b00, exp_adc_a}, {2'b00, adc_a_o});
          if (adc_b_o !== exp_adc_b)
            report_mismatch(name, "adc_b", {2'b00, exp_adc_b}, {2'b00, adc_b_o});
          if (adc_dv_o !== exp_dv)
            report_mismatch(name, "adc_dv", {15'd0, exp_dv}, {15'd0, adc_dv_o});
          if (dac_a_o !== exp_dac_a)
            report_mismatch(name, "dac_a", {2'b00, exp_dac_a}, {2'b00, dac_a_o});
          if (dac_b_o !== exp_dac_b)
            report_mismatch(name, "dac_b", {2'b00, exp_dac_b}, {2'b00, dac_b_o});
          if (core_rst_o !== 1'b0)
            report_mismatch(name, "core_rst", 16'h0000, {15'd0, core_rst_o});
          close_test(name, errs_before);
        end
      end
    end
    if (fd != 0) begin
      $fclose(fd);
      if (vec_count == 0) begin
        $display("No vectors were read from %s", VECTOR_FILE);
        err_count++;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    err_count    = 0;
    test_pass    = 0;
    test_fail    = 0;
    rst_i        = 1'b1;
    pll_locked_i = 1'b0;
    adc_raw_dv_i = 1'b0;
    loop_mode_i  = LOOP_OFF;
    adc_raw_a_i  = 16'h0000;
    adc_raw_b_i  = 16'h0000;
    asg_a_i      = 14'h0000;
    asg_b_i      = 14'h0000;
    pid_a_i      = 14'h0000;
    pid_b_i      = 14'h0000;
    repeat (RESET_CYCLES) @(posedge adc_clk);
    @(negedge adc_clk);
    rst_i = 1'b0;
    run_reset_release();
    run_lock_loss();
    run_vectors();
    $display("Tests %0d, passed %0d, failed %0d, bad checks %0d",
             test_pass + test_fail, test_pass, test_fail, err_count);
    if (test_fail == 0 && err_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Run stopped, still busy after %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

endmodule

// ==== src/afe_core.sv ====
// Analog front end top, joins the lock-based reset control with the ADC and DAC data paths

`timescale 1ns/100ps

module afe_core (
  input  logic                adc_clk,
  input  logic                rst_i,
  input  logic                pll_locked_i,
  input  logic                adc_raw_dv_i,
  input  afe_pkg::loop_mode_e loop_mode_i,
  input  afe_pkg::adc_raw_t   adc_raw_a_i,   // Parallel ADC words
  input  afe_pkg::adc_raw_t   adc_raw_b_i,
  input  afe_pkg::sample_t    asg_a_i,       // Generator samples
  input  afe_pkg::sample_t    asg_b_i,
  input  afe_pkg::sample_t    pid_a_i,       // Controller samples
  input  afe_pkg::sample_t    pid_b_i,
  output afe_pkg::sample_t    adc_a_o,
  output afe_pkg::sample_t    adc_b_o,
  output logic                adc_dv_o,
  output afe_pkg::dac_code_t  dac_a_o,       // Converter codes
  output afe_pkg::dac_code_t  dac_b_o,
  output logic                core_rst_o
);

  import afe_pkg::*;

  logic    hold_start;     // FSM to timer
  logic    hold_done;      // Timer to FSM
  logic    core_rst;       // Reset for both data paths
  sample_t loop_dac_a;     // Saturated sums for ADC loop
  sample_t loop_dac_b;

  //////////////////////////////////////////////////////////////////////////
  // Reset control
  //////////////////////////////////////////////////////////////////////////

  lock_reset_fsm u_lock_reset_fsm (
    .adc_clk      (adc_clk     ),
    .rst_i        (rst_i       ),
    .pll_locked_i (pll_locked_i),
    .hold_done_i  (hold_done   ),
    .hold_start_o (hold_start  ),
    .core_rst_o   (core_rst    )
  );

  hold_timer u_hold_timer (
    .adc_clk (adc_clk   ),
    .rst_i   (rst_i     ),
    .start_i (hold_start),
    .done_o  (hold_done )
  );

  assign core_rst_o = core_rst;

  //////////////////////////////////////////////////////////////////////////
  // Data paths
  //////////////////////////////////////////////////////////////////////////

  adc_capture u_adc_capture (
    .adc_clk     (adc_clk     ),
    .core_rst_i  (core_rst    ),
    .loop_mode_i (loop_mode_i ),
    .raw_a_i     (adc_raw_a_i ),
    .raw_b_i     (adc_raw_b_i ),
    .raw_dv_i    (adc_raw_dv_i),
    .loop_a_i    (loop_dac_a  ),
    .loop_b_i    (loop_dac_b  ),
    .adc_a_o     (adc_a_o     ),
    .adc_b_o     (adc_b_o     ),
    .adc_dv_o    (adc_dv_o    )
  );

  dac_mixer u_dac_mixer (
    .adc_clk     (adc_clk    ),
    .core_rst_i  (core_rst   ),
    .loop_mode_i (loop_mode_i),
    .asg_a_i     (asg_a_i    ),
    .asg_b_i     (asg_b_i    ),
    .pid_a_i     (pid_a_i    ),
    .pid_b_i     (pid_b_i    ),
    .raw_a_i     (adc_raw_a_i),  // Raw words for DAC loop
    .raw_b_i     (adc_raw_b_i),
    .sat_a_o     (loop_dac_a ),
    .sat_b_o     (loop_dac_b ),
    .dac_a_o     (dac_a_o    ),
    .dac_b_o     (dac_b_o    )
  );

endmodule

// ==== src/dac_mixer.sv ====
// DAC mixer, adds generator and controller samples, saturates, and encodes for the converter

`timescale 1ns/100ps

module dac_mixer (
  input  logic               adc_clk,
  input  logic               core_rst_i,   // Synchronous core reset
  input  afe_pkg::loop_mode_e loop_mode_i,
  input  afe_pkg::sample_t   asg_a_i,      // Generator
  input  afe_pkg::sample_t   asg_b_i,
  input  afe_pkg::sample_t   pid_a_i,      // Controller
  input  afe_pkg::sample_t   pid_b_i,
  input  afe_pkg::adc_raw_t  raw_a_i,
  input  afe_pkg::adc_raw_t  raw_b_i,
  output afe_pkg::sample_t   sat_a_o,      // Saturated sum, to ADC loop
  output afe_pkg::sample_t   sat_b_o,
  output afe_pkg::dac_code_t dac_a_o,
  output afe_pkg::dac_code_t dac_b_o
);

  import afe_pkg::*;

  // Clamp a one-bit-wide sum back to sample width
  function automatic sample_t sat_smp(input logic signed [SMP_W:0] sum);
    if (sum[SMP_W] != sum[SMP_W-1])            // Top two bits differ on overflow
      return {sum[SMP_W], {(SMP_W-1){~sum[SMP_W]}}};
    else
      return sum[SMP_W-1:0];
  endfunction

  // Keep sign, invert magnitude bits
  function automatic dac_code_t enc_dac(input sample_t smp);
    return {smp[SMP_W-1], ~smp[SMP_W-2:0]};
  endfunction

  logic signed [SMP_W:0] sum_a;   // One guard bit
  logic signed [SMP_W:0] sum_b;
  logic                  dac_loop; // Raw ADC onto DAC pins
  dac_code_t             code_a;
  dac_code_t             code_b;

  //////////////////////////////////////////////////////////////////////////
  // Sum and saturate
  //////////////////////////////////////////////////////////////////////////

  assign sum_a   = asg_a_i + pid_a_i;           // Sign extended to 15 bits
  assign sum_b   = asg_b_i + pid_b_i;
  assign sat_a_o = sat_smp(sum_a);
  assign sat_b_o = sat_smp(sum_b);

  //////////////////////////////////////////////////////////////////////////
  // Encode or loop, then register
  //////////////////////////////////////////////////////////////////////////

  assign dac_loop = (loop_mode_i == LOOP_DAC) || (loop_mode_i == LOOP_BOTH);

  // Loop passes raw upper bits as they are, no encoding
  assign code_a = dac_loop ? dac_code_t'(raw_a_i[ADC_RAW_W-1 -: SMP_W]) : enc_dac(sat_a_o);
  assign code_b = dac_loop ? dac_code_t'(raw_b_i[ADC_RAW_W-1 -: SMP_W]) : enc_dac(sat_b_o);

  always_ff @(posedge adc_clk) begin
    if (core_rst_i) begin
      dac_a_o <= DAC_ZERO_CODE;                 // Converter at mid scale
      dac_b_o <= DAC_ZERO_CODE;
    end else begin
      dac_a_o <= code_a;
      dac_b_o <= code_b;
    end
  end

endmodule

// ==== src/adc_capture.sv ====
// ADC sample register, takes the upper bits of the raw words or the looped DAC sums

`timescale 1ns/100ps

module adc_capture (
  input  logic               adc_clk,
  input  logic               core_rst_i,   // Synchronous core reset
  input  afe_pkg::loop_mode_e loop_mode_i,
  input  afe_pkg::adc_raw_t  raw_a_i,
  input  afe_pkg::adc_raw_t  raw_b_i,
  input  logic               raw_dv_i,
  input  afe_pkg::sample_t   loop_a_i,     // Saturated DAC sum, channel A
  input  afe_pkg::sample_t   loop_b_i,     // Saturated DAC sum, channel B
  output afe_pkg::sample_t   adc_a_o,
  output afe_pkg::sample_t   adc_b_o,
  output logic               adc_dv_o
);

  import afe_pkg::*;

  logic    adc_loop;   // DAC sample replaces ADC
  sample_t smp_a;
  sample_t smp_b;
  logic    smp_dv;

  //////////////////////////////////////////////////////////////////////////
  // Source select
  //////////////////////////////////////////////////////////////////////////

  assign adc_loop = (loop_mode_i == LOOP_ADC) || (loop_mode_i == LOOP_BOTH);

  // Upper 14 bits of the raw word are the signed sample
  assign smp_a  = adc_loop ? loop_a_i : sample_t'(raw_a_i[ADC_RAW_W-1 -: SMP_W]);
  assign smp_b  = adc_loop ? loop_b_i : sample_t'(raw_b_i[ADC_RAW_W-1 -: SMP_W]);
  assign smp_dv = adc_loop | raw_dv_i;    // Loop streams every cycle

  //////////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (core_rst_i) begin
      adc_a_o  <= '0;
      adc_b_o  <= '0;
      adc_dv_o <= 1'b0;
    end else begin
      adc_a_o  <= smp_a;
      adc_b_o  <= smp_b;
      adc_dv_o <= smp_dv;
    end
  end

endmodule

// ==== src/lock_reset_fsm.sv ====
// Core reset control, holds the core in reset until the PLL has stayed locked for the hold time

`timescale 1ns/100ps

module lock_reset_fsm (
  input  logic adc_clk,
  input  logic rst_i,
  input  logic pll_locked_i,
  input  logic hold_done_i,    // From hold_timer
  output logic hold_start_o,   // To hold_timer, first HOLD cycle
  output logic core_rst_o      // Core reset, low only in RUN
);

  import afe_pkg::*;

  rst_state_e state_q;
  rst_state_e state_d;

  //////////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      WAIT_LOCK: begin
        if (pll_locked_i)
          state_d = HOLD;
      end
      HOLD: begin
        // A done pulse still in flight from an aborted hold lands while
        // start is high, so it is ignored there
        if (hold_done_i && !hold_start_o)
          state_d = RUN;
      end
      RUN: begin
        state_d = RUN;
      end
      default: begin
        state_d = WAIT_LOCK;                   // Unused encoding
      end
    endcase

    // Loss of lock wins from any state
    if (!pll_locked_i)
      state_d = WAIT_LOCK;
  end

  //////////////////////////////////////////////////////////////////////////
  // State and outputs
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q      <= WAIT_LOCK;
      hold_start_o <= 1'b0;
      core_rst_o   <= 1'b1;                    // Core held while in reset
    end else begin
      state_q      <= state_d;
      // Start the timer on every entry into HOLD
      hold_start_o <= (state_q == WAIT_LOCK) && (state_d == HOLD);
      core_rst_o   <= (state_d != RUN);        // Registered from next state
    end
  end

endmodule

// ==== src/hold_timer.sv ====
// Hold counter for the core reset, started by the reset FSM on each entry to HOLD

`timescale 1ns/100ps

module hold_timer (
  input  logic adc_clk,
  input  logic rst_i,
  input  logic start_i,   // One-cycle start, clears the count
  output logic done_o     // One-cycle pulse on the last hold count
);

  import afe_pkg::*;

  localparam logic [HOLD_CNT_W-1:0] HOLD_LAST = HOLD_CNT_W'(RST_HOLD_CYCLES - 1);

  logic [HOLD_CNT_W-1:0] cnt_q;
  logic                  run_q;   // Counting between start and done

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;                          // Pulse by default low
      if (start_i) begin                       // Restart wins over a running count
        cnt_q <= '0;
        run_q <= 1'b1;
      end else if (run_q) begin
        cnt_q <= cnt_q + 1'b1;
        // Count lands on HOLD_LAST at this edge
        if (cnt_q == HOLD_LAST - 1'b1) begin
          done_o <= 1'b1;
          run_q  <= 1'b0;                      // Idle until next start
        end
      end
    end
  end

endmodule

// ==== src/afe_pkg.sv ====
// Shared widths, reset hold time, sample types and enums, imported by every AFE module

package afe_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Widths and constants
  //////////////////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W       = 16;         // Raw ADC word
  localparam int SMP_W           = 14;         // Converter sample
  localparam int RST_HOLD_CYCLES = 64;         // Core reset hold after lock
  localparam int HOLD_CNT_W      = 7;          // Holds 0..RST_HOLD_CYCLES-1

  // Zero sample after sign keep and magnitude inversion
  localparam logic [SMP_W-1:0] DAC_ZERO_CODE = 14'h1FFF;

  //////////////////////////////////////////////////////////////////////////
  // Sample types
  //////////////////////////////////////////////////////////////////////////

  typedef logic        [ADC_RAW_W-1:0] adc_raw_t;   // As delivered by the ADC
  typedef logic signed [SMP_W-1:0]     sample_t;    // Two's complement
  typedef logic        [SMP_W-1:0]     dac_code_t;  // Offset binary, negative slope

  //////////////////////////////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    WAIT_LOCK,                                 // PLL not locked, core in reset
    HOLD,                                      // Locked, waiting out the hold
    RUN                                        // Core released
  } rst_state_e;

  // Bit 0 loops DAC into ADC path, bit 1 loops raw ADC onto DAC pins
  typedef enum logic [1:0] {
    LOOP_OFF  = 2'd0,
    LOOP_ADC  = 2'd1,
    LOOP_DAC  = 2'd2,
    LOOP_BOTH = 2'd3
  } loop_mode_e;

endpackage
